// ==== srpt_grant_top.f ====
design/srpt_pkg.sv
design/srpt_head_if.sv
design/header_intake.sv
design/grant_issuer.sv
design/head_arbiter.sv
design/srpt_sorter.sv
design/srpt_grant_top.sv
verif/tb_srpt_grant.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_srpt_grant \
   -f srpt_grant_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_srpt_grant)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
   exit 0
fi
exit 1

// ==== verif/tb_srpt_grant.sv ====
`timescale 1ns/100ps

module tb_srpt_grant
   import srpt_pkg::*;
();

   localparam int HALF        = 20;
   localparam int DRAIN_LIMIT = 4000;
   localparam int SETTLE      = 40;
   localparam int ORDER_CNT   = 12;

   logic                ap_clk;
   logic                ap_rst;
   logic                header_empty_i;
   logic [HEADER_W-1:0] header_data_i;
   logic                header_read_o;
   logic                grant_full_i;
   logic                grant_valid_o;
   logic [PEER_W-1:0]   grant_peer_o;
   logic [RPC_W-1:0]    grant_rpc_o;
   logic [PKTS_W-1:0]   grant_pkts_o;

   logic [15:0]       lfsr_q;
   // reference model indexed by rpc
   int                remaining [2**RPC_W];
   int                granted [2**RPC_W];
   logic [PEER_W-1:0] peer_of [2**RPC_W];
   int                outstanding;
   // rpcs created in the current test and their expected totals
   logic [RPC_W-1:0]  rpc_list [$];
   int                total_list [$];
   // any grant while this is set is an error
   logic              quiet_check;
   logic              first_seen;
   logic [RPC_W-1:0]  first_rpc;
   string             test_name;
   int                test_errors;
   int                total_errors;
   int                tests_run;
   int                tests_failed;

   srpt_grant_top srpt_grant_top_i (
      .ap_clk         (ap_clk),
      .ap_rst         (ap_rst),
      .header_empty_i (header_empty_i),
      .header_data_i  (header_data_i),
      .header_read_o  (header_read_o),
      .grant_full_i   (grant_full_i),
      .grant_valid_o  (grant_valid_o),
      .grant_peer_o   (grant_peer_o),
      .grant_rpc_o    (grant_rpc_o),
      .grant_pkts_o   (grant_pkts_o)
   );

   initial begin
      ap_clk = 1'b0;
      forever #HALF ap_clk = ~ap_clk;
   end

   // 16-bit galois lfsr with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   // one lfsr step per bit
   task automatic draw_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         val = (val << 1) | int'(lfsr_q[0]);
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic report_err(input string what, input int exp, input int act);
      $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
   endtask

   task automatic report_fail(input string msg);
      $display("%s: %s", test_name, msg);
      test_errors++;
   endtask

   // grant outputs are registered and stable at the falling edge
   task automatic collect_grant();
      logic [RPC_W-1:0] rpc;
      int               pkts;
      if (grant_valid_o) begin
         rpc  = grant_rpc_o;
         pkts = int'(grant_pkts_o);
         if (quiet_check) begin
            report_fail($sformatf("grant for rpc %0d appeared while none was allowed", rpc));
         end
         if (pkts > GRANT_QUANTUM) begin
            report_err("grant pkts limit", GRANT_QUANTUM, pkts);
         end
         if (grant_peer_o != peer_of[rpc]) begin
            report_err("grant peer", int'(peer_of[rpc]), int'(grant_peer_o));
         end
         if (pkts > remaining[rpc]) begin
            report_fail($sformatf("grant of %0d packets for rpc %0d with only %0d outstanding",
                                  pkts, rpc, remaining[rpc]));
         end else begin
            remaining[rpc] -= pkts;
            outstanding    -= pkts;
         end
         granted[rpc] += pkts;
         if (!first_seen) begin
            first_seen = 1'b1;
            first_rpc  = rpc;
         end
      end
   endtask

   task automatic next_cycle();
      @(negedge ap_clk);
      collect_grant();
   endtask

   // one header for one cycle and consumed on the next rising edge
   task automatic present_header(input int peer, input logic [RPC_W-1:0] rpc,
                                 input int msg_len, input int incoming, input int offset);
      header_t h;
      h.peer         = PEER_W'(peer);
      h.rpc          = rpc;
      h.msg_len      = PKTS_W'(msg_len);
      h.incoming     = PKTS_W'(incoming);
      h.offset       = PKTS_W'(offset);
      header_empty_i = 1'b0;
      header_data_i  = h;
      #(HALF / 2);
      if (header_read_o !== 1'b1) begin
         report_err("header_read_o", 1, int'(header_read_o));
      end
      // only a first packet with packets left to grant makes an entry
      if (msg_len > incoming && offset == 0) begin
         peer_of[rpc]    = PEER_W'(peer);
         remaining[rpc] += msg_len - 1;
         outstanding    += msg_len - 1;
         rpc_list.push_back(rpc);
         total_list.push_back(msg_len - 1);
      end
      next_cycle();
      header_empty_i = 1'b1;
   endtask

   task automatic push_random(input int count, input int base);
      int peer;
      int len;
      int inc;
      for (int i = 0; i < count; i++) begin
         draw_bits(PEER_W, peer);
         draw_bits(5, len);
         len = len + 2;
         draw_bits(5, inc);
         inc = inc % len;
         present_header(peer, RPC_W'(base + i), len, inc, 0);
      end
   endtask

   // wait until the model has nothing left and then watch for strays
   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (outstanding > 0 && cycles < DRAIN_LIMIT) begin
         next_cycle();
         cycles++;
      end
      if (outstanding > 0) begin
         report_fail($sformatf("timeout with %0d packets never granted", outstanding));
      end
      for (int i = 0; i < SETTLE; i++) begin
         next_cycle();
      end
   endtask

   task automatic check_totals();
      for (int i = 0; i < rpc_list.size(); i++) begin
         if (granted[rpc_list[i]] != total_list[i]) begin
            report_err($sformatf("total for rpc %0d", rpc_list[i]), total_list[i],
                       granted[rpc_list[i]]);
         end
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      first_seen  = 1'b0;
      rpc_list.delete();
      total_list.delete();
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, test_errors);
      end
   endtask

   task automatic quiet_after_reset();
      start_test("reset_quiet");
      quiet_check = 1'b1;
      for (int i = 0; i < 50; i++) begin
         next_cycle();
         if (header_read_o !== 1'b0) begin
            report_err("header_read_o", 0, int'(header_read_o));
         end
      end
      quiet_check = 1'b0;
      finish_test();
   endtask

   task automatic filter_headers();
      int peer;
      int len;
      int inc;
      int off;
      start_test("filtering");
      quiet_check = 1'b1;
      for (int i = 0; i < 8; i++) begin
         draw_bits(PEER_W, peer);
         draw_bits(5, len);
         draw_bits(PKTS_W, off);
         if (i % 2 == 0) begin
            // first packet where incoming already covers the message
            draw_bits(3, inc);
            inc = len + inc;
            off = 0;
         end else begin
            // grantable but a later packet
            len = len + 2;
            inc = 0;
            off = off | 1;
         end
         present_header(peer, RPC_W'(1000 + i), len, inc, off);
      end
      for (int i = 0; i < 60; i++) begin
         next_cycle();
      end
      quiet_check = 1'b0;
      finish_test();
   endtask

   task automatic grant_totals();
      int n;
      start_test("totals");
      draw_bits(2, n);
      push_random(8 + n, 2000);
      wait_drain();
      check_totals();
      finish_test();
   endtask

   task automatic shortest_first();
      int               lens [ORDER_CNT];
      int               r;
      int               tmp;
      int               peer;
      int               best_len;
      int               cycles;
      logic [RPC_W-1:0] best_rpc;
      start_test("srpt_order");
      // distinct lengths 4 apart plus a random offset
      for (int i = 0; i < ORDER_CNT; i++) begin
         draw_bits(2, r);
         lens[i] = 2 + 4 * i + r;
      end
      // shuffle so the shortest is not pushed first
      for (int i = ORDER_CNT - 1; i > 0; i--) begin
         draw_bits(4, r);
         r       = r % (i + 1);
         tmp     = lens[i];
         lens[i] = lens[r];
         lens[r] = tmp;
      end
      grant_full_i = 1'b1;
      quiet_check  = 1'b1;
      best_len     = 1 << PKTS_W;
      best_rpc     = '0;
      for (int i = 0; i < ORDER_CNT; i++) begin
         draw_bits(PEER_W, peer);
         present_header(peer, RPC_W'(3000 + i), lens[i], 0, 0);
         if (lens[i] < best_len) begin
            best_len = lens[i];
            best_rpc = RPC_W'(3000 + i);
         end
      end
      // let the network settle
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         next_cycle();
      end
      first_seen   = 1'b0;
      grant_full_i = 1'b0;
      quiet_check  = 1'b0;
      cycles       = 0;
      while (!first_seen && cycles < 200) begin
         next_cycle();
         cycles++;
      end
      if (!first_seen) begin
         report_fail("timeout waiting for the first grant");
      end else if (first_rpc != best_rpc) begin
         report_err("first grant rpc", int'(best_rpc), int'(first_rpc));
      end
      wait_drain();
      check_totals();
      finish_test();
   endtask

   task automatic hold_while_full();
      start_test("backpressure");
      push_random(10, 4000);
      // a grant decided before the full edge may still show here
      next_cycle();
      grant_full_i = 1'b1;
      quiet_check  = 1'b1;
      if (outstanding == 0) begin
         report_fail("no packets left to hold back");
      end
      for (int i = 0; i < 60; i++) begin
         next_cycle();
      end
      grant_full_i = 1'b0;
      quiet_check  = 1'b0;
      wait_drain();
      check_totals();
      finish_test();
   endtask

   initial begin
      ap_rst         = 1'b1;
      header_empty_i = 1'b1;
      header_data_i  = '0;
      grant_full_i   = 1'b0;
      lfsr_q         = 16'd23640;
      outstanding    = 0;
      quiet_check    = 1'b0;
      first_seen     = 1'b0;
      first_rpc      = '0;
      test_name      = "reset";
      test_errors    = 0;
      total_errors   = 0;
      tests_run      = 0;
      tests_failed   = 0;
      repeat (16) begin
         @(negedge ap_clk);
      end
      ap_rst = 1'b0;
      quiet_after_reset();
      filter_headers();
      grant_totals();
      shortest_first();
      hold_while_full();
      $display("tests %0d failed %0d errors %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== design/srpt_grant_top.sv ====
`timescale 1ns/100ps

module srpt_grant_top
   import srpt_pkg::*;
(
   input  logic                ap_clk,
   input  logic                ap_rst,
   input  logic                header_empty_i,
   input  logic [HEADER_W-1:0] header_data_i,
   output logic                header_read_o,
   input  logic                grant_full_i,
   output logic                grant_valid_o,
   output logic [PEER_W-1:0]   grant_peer_o,
   output logic [RPC_W-1:0]    grant_rpc_o,
   output logic [PKTS_W-1:0]   grant_pkts_o
);

   // intake and issuer paths to the head slot
   srpt_head_if push_if ();
   srpt_head_if upd_if ();

   logic        op_push;
   logic        op_replace;
   srpt_entry_t op_entry;
   srpt_entry_t head;

   // both requesters see the same head
   assign push_if.head = head;
   assign upd_if.head  = head;

   header_intake header_intake_i (
      .header_empty_i (header_empty_i),
      .header_data_i  (header_t'(header_data_i)),
      .header_read_o  (header_read_o),
      .push_port      (push_if)
   );

   grant_issuer grant_issuer_i (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .grant_full_i  (grant_full_i),
      .grant_valid_o (grant_valid_o),
      .grant_peer_o  (grant_peer_o),
      .grant_rpc_o   (grant_rpc_o),
      .grant_pkts_o  (grant_pkts_o),
      .upd_port      (upd_if)
   );

   head_arbiter head_arbiter_i (
      .push_port    (push_if),
      .upd_port     (upd_if),
      .op_push_o    (op_push),
      .op_replace_o (op_replace),
      .op_entry_o   (op_entry)
   );

   srpt_sorter srpt_sorter_i (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .op_push_i    (op_push),
      .op_replace_i (op_replace),
      .op_entry_i   (op_entry),
      .head_o       (head)
   );

endmodule

// ==== design/srpt_sorter.sv ====
`timescale 1ns/100ps

module srpt_sorter
   import srpt_pkg::*;
(
   input  logic        ap_clk,
   input  logic        ap_rst,
   input  logic        op_push_i,
   input  logic        op_replace_i,
   input  srpt_entry_t op_entry_i,
   output srpt_entry_t head_o
);

   // slot 0 is the head
   srpt_entry_t slots_q [QUEUE_DEPTH];
   // results of the three possible updates
   srpt_entry_t even_d [QUEUE_DEPTH];
   srpt_entry_t odd_d [QUEUE_DEPTH];
   srpt_entry_t push_d [QUEUE_DEPTH];
   // 0 = even pairs next, 1 = odd pairs next
   logic        phase_q;
   logic        new_wins;

   // a strictly better than b, ties keep the current order
   function automatic logic better(input srpt_entry_t a, input srpt_entry_t b);
      logic [PRIO_W-1:0] prio_a;
      logic [PRIO_W-1:0] prio_b;
      logic [PKTS_W-1:0] cnt_a;
      logic [PKTS_W-1:0] cnt_b;
      prio_a = a.sort.key[PRIO_W-1:0];
      prio_b = b.sort.key[PRIO_W-1:0];
      cnt_a  = a.sort.key[KEY_W-1:PRIO_W];
      cnt_b  = b.sort.key[KEY_W-1:PRIO_W];
      if (prio_a != prio_b) begin
         better = (prio_a < prio_b);
      end else begin
         better = (cnt_a < cnt_b);
      end
   endfunction

   assign head_o = slots_q[0];

   // even step, pairs (0,1) (2,3) ...
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i += 2) begin
         if (better(slots_q[i+1], slots_q[i])) begin
            even_d[i]   = slots_q[i+1];
            even_d[i+1] = slots_q[i];
         end else begin
            even_d[i]   = slots_q[i];
            even_d[i+1] = slots_q[i+1];
         end
      end
   end

   // odd step, pairs (1,2) (3,4) ...
   // head and bottom slot sit this one out
   always_comb begin
      odd_d[0]             = slots_q[0];
      odd_d[QUEUE_DEPTH-1] = slots_q[QUEUE_DEPTH-1];
      for (int i = 1; i < QUEUE_DEPTH - 1; i += 2) begin
         if (better(slots_q[i+1], slots_q[i])) begin
            odd_d[i]   = slots_q[i+1];
            odd_d[i+1] = slots_q[i];
         end else begin
            odd_d[i]   = slots_q[i];
            odd_d[i+1] = slots_q[i+1];
         end
      end
   end

   // push: new entry meets the old head, loser drops to slot 1
   // everything below shifts down one, bottom entry falls off
   assign new_wins = better(op_entry_i, slots_q[0]);

   always_comb begin
      push_d[0] = new_wins ? op_entry_i : slots_q[0];
      push_d[1] = new_wins ? slots_q[0] : op_entry_i;
      for (int i = 2; i < QUEUE_DEPTH; i++) begin
         push_d[i] = slots_q[i-1];
      end
   end

   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         phase_q <= 1'b0;
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            slots_q[i] <= EMPTY_ENTRY;
         end
      end else if (op_push_i) begin
         slots_q <= push_d;
      end else if (op_replace_i) begin
         // rest of the array holds
         slots_q[0] <= op_entry_i;
      end else begin
         // idle, one sort step and flip the phase
         if (phase_q) begin
            slots_q <= odd_d;
         end else begin
            slots_q <= even_d;
         end
         phase_q <= ~phase_q;
      end
   end

   // an active head only leaves through the issuer
   a_head_stays_active: assert property (
      @(posedge ap_clk) disable iff (ap_rst)
      (head_o.fld.prio == SRPT_ACTIVE && !op_replace_i) |=> (head_o.fld.prio == SRPT_ACTIVE)
   ) else $error("active head lost without a replace");

endmodule

// ==== design/head_arbiter.sv ====
`timescale 1ns/100ps

module head_arbiter
   import srpt_pkg::*;
(
   srpt_head_if.arbiter push_port,
   srpt_head_if.arbiter upd_port,
   output logic         op_push_o,
   output logic         op_replace_o,
   output srpt_entry_t  op_entry_o
);

   logic push_win;
   logic upd_win;

   // intake has fixed priority, its header cannot wait
   assign push_win = push_port.req;
   // issuer only gets the slot in a cycle without a push
   assign upd_win  = upd_port.req & ~push_port.req;

   assign push_port.gnt = push_win;
   assign upd_port.gnt  = upd_win;

   // winning request becomes the sorter operation
   assign op_push_o    = push_win;
   assign op_replace_o = upd_win;

   // entry of the winner, the issuer's when idle
   always_comb begin
      if (push_win) begin
         op_entry_o = push_port.entry;
      end else begin
         op_entry_o = upd_port.entry;
      end
   end

   always_comb begin
      assert final (!(op_push_o && op_replace_o))
         else $error("push and replace in the same cycle");
   end

endmodule

// ==== design/grant_issuer.sv ====
`timescale 1ns/100ps

module grant_issuer
   import srpt_pkg::*;
(
   input  logic              ap_clk,
   input  logic              ap_rst,
   input  logic              grant_full_i,
   output logic              grant_valid_o,
   output logic [PEER_W-1:0] grant_peer_o,
   output logic [RPC_W-1:0]  grant_rpc_o,
   output logic [PKTS_W-1:0] grant_pkts_o,
   srpt_head_if.requester    upd_port
);

   srpt_entry_t       head;
   srpt_entry_t       next_entry;
   logic              head_active;
   logic [PKTS_W-1:0] grant_pkts;
   logic [PKTS_W-1:0] remain;

   assign head        = upd_port.head;
   assign head_active = (head.fld.prio == SRPT_ACTIVE);

   // grant covers at most one quantum
   assign grant_pkts = (head.fld.grantable_pkts < PKTS_W'(GRANT_QUANTUM))
                     ? head.fld.grantable_pkts : PKTS_W'(GRANT_QUANTUM);
   assign remain     = head.fld.grantable_pkts - grant_pkts;

   // ask for the head whenever there is room downstream
   assign upd_port.req = head_active & ~grant_full_i;

   // reduced head or a vacant slot once fully granted
   always_comb begin
      next_entry                    = head;
      next_entry.fld.recv_pkts      = '0;
      next_entry.fld.grantable_pkts = remain;
      if (remain == '0) begin
         next_entry = EMPTY_ENTRY;
      end
   end

   assign upd_port.entry = next_entry;

   // a single-packet message has nothing to grant
   // its slot is cleared with no grant out
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         grant_valid_o <= 1'b0;
      end else begin
         grant_valid_o <= upd_port.gnt & (grant_pkts != '0);
      end
   end

   // grant fields captured with the head they came from
   always_ff @(posedge ap_clk) begin
      if (upd_port.gnt) begin
         grant_peer_o <= head.fld.peer;
         grant_rpc_o  <= head.fld.rpc;
         grant_pkts_o <= grant_pkts;
      end
   end

   a_pkts_nonzero: assert property (
      @(posedge ap_clk) disable iff (ap_rst) grant_valid_o |-> (grant_pkts_o != '0)
   ) else $error("grant issued with zero packets");

endmodule

// ==== design/header_intake.sv ====
`timescale 1ns/100ps

module header_intake
   import srpt_pkg::*;
(
   input  logic           header_empty_i,
   input  header_t        header_data_i,
   output logic           header_read_o,
   srpt_head_if.requester push_port
);

   logic        first_pkt;
   logic        has_grantable;
   srpt_entry_t new_entry;

   // every header is consumed in the cycle it shows up
   assign header_read_o = ~header_empty_i;

   // only the first unscheduled packet creates an entry
   assign first_pkt = (header_data_i.offset == '0);
   // nothing to grant once incoming covers the message
   assign has_grantable = (header_data_i.msg_len > header_data_i.incoming);

   assign push_port.req = ~header_empty_i & first_pkt & has_grantable;

   // new entry, one packet already received
   always_comb begin
      new_entry.fld.peer           = header_data_i.peer;
      new_entry.fld.rpc            = header_data_i.rpc;
      new_entry.fld.recv_pkts      = PKTS_W'(1);
      // msg_len > incoming >= 0 keeps this from wrapping
      new_entry.fld.grantable_pkts = header_data_i.msg_len - PKTS_W'(1);
      new_entry.fld.prio           = SRPT_ACTIVE;
   end

   assign push_port.entry = new_entry;

   // a header is never held back, so a push must win at once
   always_comb begin
      assert final (!push_port.req || push_port.gnt)
         else $error("push request not granted in the same cycle");
   end

endmodule

// ==== design/srpt_head_if.sv ====
`timescale 1ns/100ps

// one requester's path to the head slot
interface srpt_head_if
   import srpt_pkg::*;
();

   // request strobe and the entry that goes with it
   logic        req;
   srpt_entry_t entry;
   // served in the cycle this is high
   logic        gnt;
   // current slot 0 of the sorter
   srpt_entry_t head;

   modport requester (
      output req,
      output entry,
      input  gnt,
      input  head
   );

   modport arbiter (
      input  req,
      input  entry,
      output gnt
   );

   modport queue (
      output head
   );

endinterface

// ==== design/srpt_pkg.sv ====
package srpt_pkg;

   // field widths of a queue entry and of a header word
   localparam int PEER_W = 14;
   localparam int RPC_W  = 14;
   localparam int PKTS_W = 10;
   localparam int PRIO_W = 3;

   // 51 bits: peer, rpc, recv, grantable, prio
   localparam int ENTRY_W = PEER_W + RPC_W + 2 * PKTS_W + PRIO_W;
   // grantable count plus status, the part the sort looks at
   localparam int KEY_W = PKTS_W + PRIO_W;
   // 58 bits: peer, rpc, msg_len, incoming, offset
   localparam int HEADER_W = PEER_W + RPC_W + 3 * PKTS_W;

   // sorter slots
   localparam int QUEUE_DEPTH = 16;
   // max packets covered by one grant
   localparam int GRANT_QUANTUM = 4;

   // status codes, lower sorts first
   localparam logic [PRIO_W-1:0] SRPT_ACTIVE = 3'd0;
   localparam logic [PRIO_W-1:0] SRPT_EMPTY  = 3'd7;

   // vacant slot, also the reset value of every slot
   localparam logic [ENTRY_W-1:0] EMPTY_ENTRY = {{(ENTRY_W - PRIO_W){1'b0}}, SRPT_EMPTY};

   // field view of an entry
   typedef struct packed {
      logic [PEER_W-1:0] peer;
      logic [RPC_W-1:0]  rpc;
      logic [PKTS_W-1:0] recv_pkts;
      logic [PKTS_W-1:0] grantable_pkts;
      logic [PRIO_W-1:0] prio;
   } srpt_fields_t;

   // comparator view, key = {grantable, prio}
   typedef struct packed {
      logic [ENTRY_W-KEY_W-1:0] ident;
      logic [KEY_W-1:0]         key;
   } srpt_sort_t;

   typedef union packed {
      srpt_fields_t fld;
      srpt_sort_t   sort;
   } srpt_entry_t;

   // incoming data packet header
   typedef struct packed {
      logic [PEER_W-1:0] peer;
      logic [RPC_W-1:0]  rpc;
      logic [PKTS_W-1:0] msg_len;
      logic [PKTS_W-1:0] incoming;
      logic [PKTS_W-1:0] offset;
   } header_t;

endpackage
